// ==== verilog/fixedPkg.sv ====
package fixedPkg;

  // Integer and fraction split of every Q10.10 value in the datapath
  localparam int INT_BITS  = 10;
  localparam int FRAC_BITS = 10;
  localparam int FIX_BITS  = INT_BITS + FRAC_BITS;

  // Signed Q10.10 value for positions, directions and distances
  typedef logic signed [FIX_BITS-1:0] fixT;

  // Track distances can overflow past the signed range once, so they are compared unsigned
  typedef logic [FIX_BITS-1:0] uFixT;

  // Full-width product of two fixT operands before rescaling
  typedef logic signed [2*FIX_BITS-1:0] prodT;

  // Map grid coordinate, taken from the integer part of a position
  typedef logic [INT_BITS-1:0] cellT;

  // Wall half-size in screen lines, and the 64-entry texture column
  typedef logic [10:0] sizeT;
  typedef logic [5:0]  texUT;

  // Handy constants: 1.0 and the largest positive value
  localparam fixT FIX_ONE = fixT'(1) <<< FRAC_BITS;
  localparam fixT FIX_MAX = {1'b0, {(FIX_BITS-1){1'b1}}};

endpackage

// ==== verilog/tracerPkg.sv ====
package tracerPkg;

  // Per-row controller sequence
  // Two reciprocal round trips give the step distances, then the partial
  // track distances are formed, the grid is walked, and a third reciprocal
  // gives the wall size before the texture column is worked out
  typedef enum logic [3:0] {
    StepXReq,
    StepXWait,
    StepYReq,
    StepYWait,
    TracePrepX,
    TracePrepY,
    TraceStep,
    SizeReq,
    SizeWait,
    CalcTexU,
    TraceDone
  } traceStateT;

  // Which value is fed to the shared reciprocal
  typedef enum logic [1:0] {
    RcpRayX,
    RcpRayY,
    RcpVdist
  } rcpSrcT;

  // Map cell contents; zero is an empty cell and anything else is a wall
  typedef logic [1:0] wallT;

endpackage

// ==== verilog/rayStepper.sv ====
`timescale 1ns/10ps

module rayStepper
  import fixedPkg::*;
#(
  parameter int START_ROWS = 272
) (
  input  logic clk,
  input  logic do_reset,
  input  logic i_vsync,
  input  logic i_rowNext,
  input  fixT  i_facingX,
  input  fixT  i_facingY,
  input  fixT  i_vplaneX,
  input  fixT  i_vplaneY,
  output fixT  o_rayDirX,
  output fixT  o_rayDirY
);

  // Deflection from the facing vector, kept at 256 times its real scale
  // so that adding a whole camera plane per row loses no precision
  fixT deflectX;
  fixT deflectY;

  // Value for the top row, which sits START_ROWS planes to the negative side
  fixT startX;
  fixT startY;

  assign startX = fixT'(-(i_vplaneX * START_ROWS));
  assign startY = fixT'(-(i_vplaneY * START_ROWS));

  // Frame start reloads the top row, each finished row moves one plane over
  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      deflectX <= startX;
      deflectY <= startY;
    end else if (i_rowNext) begin
      deflectX <= deflectX + i_vplaneX;
      deflectY <= deflectY + i_vplaneY;
    end
  end

  // Scale the deflection back down and add it to the centre ray
  assign o_rayDirX = i_facingX + (deflectX >>> 8);
  assign o_rayDirY = i_facingY + (deflectY >>> 8);

endmodule

// ==== verilog/reciprocalUnit.sv ====
`timescale 1ns/10ps

module reciprocalUnit
  import fixedPkg::*;
(
  input  logic clk,
  input  logic do_reset,
  input  logic i_start,
  input  fixT  i_value,
  output fixT  o_recip,
  output logic o_done
);

  // 2^20 divided by a raw value needs one quotient bit more than a fixT holds
  localparam int Q_BITS = FIX_BITS + 1;
  localparam logic [4:0] TOP_BIT = 5'(Q_BITS - 1);

  uFixT                divisor;
  uFixT                remainder;
  logic [FIX_BITS-1:0] quotient;
  logic [4:0]          bitIdx;
  logic                busy;

  uFixT                absValue;
  logic [FIX_BITS:0]   trial;
  logic                qBit;
  logic [FIX_BITS:0]   fullQ;
  uFixT                nextRem;
  fixT                 clipped;

  // Magnitude of the input; the most negative value maps to 2^19 unsigned
  assign absValue = i_value[FIX_BITS-1] ? uFixT'(-i_value) : uFixT'(i_value);

  // The dividend is a lone one in bit 20, so only the first step shifts in a 1
  assign trial   = {remainder, bitIdx == TOP_BIT};
  assign qBit    = trial >= {1'b0, divisor};
  assign nextRem = qBit ? uFixT'(trial - {1'b0, divisor}) : uFixT'(trial);
  assign fullQ   = {quotient, qBit};

  // Divide by zero, or a quotient above the positive range, clips to the max
  assign clipped = (divisor == '0 || fullQ[FIX_BITS:FIX_BITS-1] != 2'b00) ?
                   FIX_MAX : fixT'(fullQ[FIX_BITS-1:0]);

  // Busy runs for one cycle per quotient bit and o_done marks the last one
  always_ff @(posedge clk) begin
    if (do_reset) begin
      busy   <= 1'b0;
      o_done <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        busy <= 1'b1;
      end else if (busy && bitIdx == '0) begin
        busy   <= 1'b0;
        o_done <= 1'b1;
      end
    end
  end

  // Restoring division, most significant quotient bit first
  always_ff @(posedge clk) begin
    if (i_start) begin
      divisor   <= absValue;
      remainder <= '0;
      quotient  <= '0;
      bitIdx    <= TOP_BIT;
    end else if (busy) begin
      remainder <= nextRem;
      quotient  <= fullQ[FIX_BITS-1:0];
      bitIdx    <= bitIdx - 5'd1;
      // The result register holds until the next request is started
      if (bitIdx == '0) begin
        o_recip <= clipped;
      end
    end
  end

endmodule

// ==== verilog/gridWalker.sv ====
`timescale 1ns/10ps

module gridWalker
  import fixedPkg::*, tracerPkg::*;
#(
  parameter int MAP_W_BITS = 4,
  parameter int MAP_H_BITS = 4
) (
  input  logic                  clk,
  input  logic                  do_reset,
  input  logic                  i_initX,
  input  logic                  i_initY,
  input  logic                  i_walk,
  input  uFixT                  i_trackInit,
  input  cellT                  i_startCellX,
  input  cellT                  i_startCellY,
  input  fixT                   i_stepDistX,
  input  fixT                   i_stepDistY,
  input  fixT                   i_rayDirX,
  input  fixT                   i_rayDirY,
  input  wallT                  i_mapVal,
  output logic [MAP_W_BITS-1:0] o_mapCol,
  output logic [MAP_H_BITS-1:0] o_mapRow,
  output logic                  o_hit,
  output wallT                  o_wall,
  output logic                  o_side,
  output fixT                   o_visualDist
);

  // Cell under test, and distance along the ray to the next X and Y gridline
  cellT mapX;
  cellT mapY;
  uFixT trackX;
  uFixT trackY;

  logic rayXPos;
  logic rayYPos;
  logic stepX;
  logic advance;

  // Direction of travel on each axis; a zero component counts as negative
  assign rayXPos = i_rayDirX > 0;
  assign rayYPos = i_rayDirY > 0;

  // Cross whichever gridline is nearer, and on a tie take the Y line
  assign stepX = trackX < trackY;

  // The map ROM answers in the same cycle, so a hit is seen combinationally
  assign o_mapCol = mapX[MAP_W_BITS-1:0];
  assign o_mapRow = mapY[MAP_H_BITS-1:0];
  assign o_hit    = i_mapVal != '0;

  // Stepping stops as soon as the current cell is solid
  assign advance = i_walk && !o_hit;

  // Cell position, side and wall ID
  always_ff @(posedge clk) begin
    if (do_reset) begin
      mapX   <= '0;
      mapY   <= '0;
      o_side <= 1'b0;
      o_wall <= '0;
    end else if (i_initX) begin
      mapX <= i_startCellX;
    end else if (i_initY) begin
      mapY <= i_startCellY;
    end else if (i_walk && o_hit) begin
      o_wall <= i_mapVal;
    end else if (advance) begin
      if (stepX) begin
        mapX   <= rayXPos ? mapX + 1'b1 : mapX - 1'b1;
        o_side <= 1'b0;
      end else begin
        mapY   <= rayYPos ? mapY + 1'b1 : mapY - 1'b1;
        o_side <= 1'b1;
      end
    end
  end

  // Distances; the wall distance is the track value before the crossing step
  always_ff @(posedge clk) begin
    if (i_initX) begin
      trackX <= i_trackInit;
    end else if (i_initY) begin
      trackY <= i_trackInit;
    end else if (advance) begin
      if (stepX) begin
        o_visualDist <= fixT'(trackX);
        trackX       <= trackX + uFixT'(i_stepDistX);
      end else begin
        o_visualDist <= fixT'(trackY);
        trackY       <= trackY + uFixT'(i_stepDistY);
      end
    end
  end

endmodule

// ==== verilog/traceControl.sv ====
`timescale 1ns/10ps

module traceControl
  import fixedPkg::*, tracerPkg::*;
(
  input  logic clk,
  input  logic do_reset,
  input  logic i_vsync,
  input  logic i_hmax,
  input  fixT  i_playerX,
  input  fixT  i_playerY,
  input  fixT  i_rayDirX,
  input  fixT  i_rayDirY,
  input  fixT  i_recip,
  input  logic i_rcpDone,
  input  logic i_hit,
  input  logic i_side,
  input  fixT  i_visualDist,
  output logic o_rcpStart,
  output fixT  o_rcpValue,
  output logic o_initX,
  output logic o_initY,
  output uFixT o_trackInit,
  output cellT o_startCellX,
  output cellT o_startCellY,
  output fixT  o_stepDistX,
  output fixT  o_stepDistY,
  output logic o_walk,
  output logic o_rowNext,
  output logic o_load,
  output sizeT o_size,
  output texUT o_texU
);

  traceStateT state;
  rcpSrcT     rcpSrc;

  // Reciprocals of the ray components, the ray length per grid cell
  fixT stepDistX;
  fixT stepDistY;

  logic rayXPos;
  logic rayYPos;
  fixT  fracX;
  fixT  fracY;
  fixT  partialX;
  fixT  partialY;

  // Shared multiplier operands and the product rescaled to Q10.10
  fixT  mulA;
  fixT  mulB;
  prodT product;
  fixT  mulFix;
  fixT  hitPoint;
  logic texMirror;

  assign rayXPos = i_rayDirX > 0;
  assign rayYPos = i_rayDirY > 0;

  // Fraction of a cell from the player to the first gridline in the ray's direction
  assign fracX    = fixT'(i_playerX[FRAC_BITS-1:0]);
  assign fracY    = fixT'(i_playerY[FRAC_BITS-1:0]);
  assign partialX = rayXPos ? FIX_ONE - fracX : fracX;
  assign partialY = rayYPos ? FIX_ONE - fracY : fracY;

  // Operands follow the state that consumes the product
  // Outside the two prep states the multiplier works on the hit point
  always_comb begin
    case (state)
      TracePrepX: begin
        mulA = stepDistX;
        mulB = partialX;
      end
      TracePrepY: begin
        mulA = stepDistY;
        mulB = partialY;
      end
      default: begin
        mulA = i_side ? i_rayDirX : i_rayDirY;
        mulB = i_visualDist;
      end
    endcase
  end

  assign product = mulA * mulB;
  assign mulFix  = product[FRAC_BITS +: FIX_BITS];

  // Position along the wall face that was hit, on the axis the wall runs along
  assign hitPoint = mulFix + (i_side ? i_playerX : i_playerY);

  // Flip the texture on two of the four faces so it reads the same way round
  assign texMirror = i_side ? rayYPos : !rayXPos;

  // Reciprocal input selection
  always_comb begin
    case (state)
      StepXReq, StepXWait: rcpSrc = RcpRayX;
      StepYReq, StepYWait: rcpSrc = RcpRayY;
      default:             rcpSrc = RcpVdist;
    endcase
  end

  always_comb begin
    case (rcpSrc)
      RcpRayX: o_rcpValue = i_rayDirX;
      RcpRayY: o_rcpValue = i_rayDirY;
      default: o_rcpValue = i_visualDist;
    endcase
  end

  // Strobes to the reciprocal, the walker, the ray stepper and the output side
  assign o_rcpStart   = state inside {StepXReq, StepYReq, SizeReq};
  assign o_initX      = state == TracePrepX;
  assign o_initY      = state == TracePrepY;
  assign o_walk       = state == TraceStep;
  assign o_load       = state == TraceDone && i_hmax;
  assign o_rowNext    = o_load;
  assign o_trackInit  = uFixT'(mulFix);
  assign o_startCellX = i_playerX[FIX_BITS-1:FRAC_BITS];
  assign o_startCellY = i_playerY[FIX_BITS-1:FRAC_BITS];
  assign o_stepDistX  = stepDistX;
  assign o_stepDistY  = stepDistY;

  // Row sequence; vsync holds the FSM at the first step of the frame
  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      state <= StepXReq;
    end else begin
      case (state)
        StepXReq:   state <= StepXWait;
        StepXWait:  if (i_rcpDone) state <= StepYReq;
        StepYReq:   state <= StepYWait;
        StepYWait:  if (i_rcpDone) state <= TracePrepX;
        TracePrepX: state <= TracePrepY;
        TracePrepY: state <= TraceStep;
        TraceStep:  if (i_hit) state <= SizeReq;
        SizeReq:    state <= SizeWait;
        SizeWait:   if (i_rcpDone) state <= CalcTexU;
        CalcTexU:   state <= TraceDone;
        TraceDone:  if (i_hmax) state <= StepXReq;
        default:    state <= StepXReq;
      endcase
    end
  end

  // Step distances are caught as the reciprocal finishes
  // Size is 256 / distance, which is the distance reciprocal shifted down by 2
  always_ff @(posedge clk) begin
    if (state == StepXWait && i_rcpDone) begin
      stepDistX <= i_recip;
    end
    if (state == StepYWait && i_rcpDone) begin
      stepDistY <= i_recip;
    end
    if (state == CalcTexU) begin
      o_size <= i_recip[12:2];
      o_texU <= hitPoint[FRAC_BITS-1 -: $bits(texUT)] ^ {$bits(texUT){texMirror}};
    end
  end

endmodule

// ==== verilog/rowResult.sv ====
`timescale 1ns/10ps

module rowResult
  import fixedPkg::*, tracerPkg::*;
(
  input  logic clk,
  input  logic do_reset,
  input  logic i_vsync,
  input  logic i_load,
  input  wallT i_wall,
  input  logic i_side,
  input  sizeT i_size,
  input  texUT i_texU,
  output logic o_rowStrobe,
  output wallT o_wall,
  output logic o_side,
  output sizeT o_size,
  output texUT o_texU
);

  // Holds the finished row for the whole line while the next row is traced
  // A new frame starts from a blank result
  always_ff @(posedge clk) begin
    if (do_reset || i_vsync) begin
      o_rowStrobe <= 1'b0;
      o_wall      <= '0;
      o_side      <= 1'b0;
      o_size      <= '0;
      o_texU      <= '0;
    end else begin
      // One-cycle pulse that lines up with the newly presented values
      o_rowStrobe <= i_load;
      if (i_load) begin
        o_wall <= i_wall;
        o_side <= i_side;
        o_size <= i_size;
        o_texU <= i_texU;
      end
    end
  end

endmodule

// ==== verilog/wallTracer.sv ====
`timescale 1ns/10ps

module wallTracer
  import fixedPkg::*, tracerPkg::*;
#(
  parameter int MAP_W_BITS = 4,
  parameter int MAP_H_BITS = 4,
  parameter int START_ROWS = 272
) (
  input  logic                  clk,
  input  logic                  do_reset,
  input  logic                  i_vsync,
  input  logic                  i_hmax,
  input  fixT                   i_playerX,
  input  fixT                   i_playerY,
  input  fixT                   i_facingX,
  input  fixT                   i_facingY,
  input  fixT                   i_vplaneX,
  input  fixT                   i_vplaneY,
  output logic [MAP_W_BITS-1:0] o_mapCol,
  output logic [MAP_H_BITS-1:0] o_mapRow,
  input  wallT                  i_mapVal,
  output logic                  o_rowStrobe,
  output wallT                  o_wall,
  output logic                  o_side,
  output sizeT                  o_size,
  output texUT                  o_texU
);

  // Ray for the row being traced
  fixT  rayDirX;
  fixT  rayDirY;
  logic rowNext;

  // Shared reciprocal handshake
  logic rcpStart;
  fixT  rcpValue;
  fixT  recip;
  logic rcpDone;

  // Grid walk setup and results
  logic initX;
  logic initY;
  logic walk;
  uFixT trackInit;
  cellT startCellX;
  cellT startCellY;
  fixT  stepDistX;
  fixT  stepDistY;
  logic hit;
  wallT wall;
  logic side;
  fixT  visualDist;

  // Finished row on its way to the output registers
  logic load;
  sizeT size;
  texUT texU;

  rayStepper #(
    .START_ROWS (START_ROWS)
  ) u_rayStepper (
    .clk       (clk),
    .do_reset  (do_reset),
    .i_vsync   (i_vsync),
    .i_rowNext (rowNext),
    .i_facingX (i_facingX),
    .i_facingY (i_facingY),
    .i_vplaneX (i_vplaneX),
    .i_vplaneY (i_vplaneY),
    .o_rayDirX (rayDirX),
    .o_rayDirY (rayDirY)
  );

  traceControl u_traceControl (
    .clk          (clk),
    .do_reset     (do_reset),
    .i_vsync      (i_vsync),
    .i_hmax       (i_hmax),
    .i_playerX    (i_playerX),
    .i_playerY    (i_playerY),
    .i_rayDirX    (rayDirX),
    .i_rayDirY    (rayDirY),
    .i_recip      (recip),
    .i_rcpDone    (rcpDone),
    .i_hit        (hit),
    .i_side       (side),
    .i_visualDist (visualDist),
    .o_rcpStart   (rcpStart),
    .o_rcpValue   (rcpValue),
    .o_initX      (initX),
    .o_initY      (initY),
    .o_trackInit  (trackInit),
    .o_startCellX (startCellX),
    .o_startCellY (startCellY),
    .o_stepDistX  (stepDistX),
    .o_stepDistY  (stepDistY),
    .o_walk       (walk),
    .o_rowNext    (rowNext),
    .o_load       (load),
    .o_size       (size),
    .o_texU       (texU)
  );

  reciprocalUnit u_reciprocalUnit (
    .clk      (clk),
    .do_reset (do_reset),
    .i_start  (rcpStart),
    .i_value  (rcpValue),
    .o_recip  (recip),
    .o_done   (rcpDone)
  );

  gridWalker #(
    .MAP_W_BITS (MAP_W_BITS),
    .MAP_H_BITS (MAP_H_BITS)
  ) u_gridWalker (
    .clk          (clk),
    .do_reset     (do_reset),
    .i_initX      (initX),
    .i_initY      (initY),
    .i_walk       (walk),
    .i_trackInit  (trackInit),
    .i_startCellX (startCellX),
    .i_startCellY (startCellY),
    .i_stepDistX  (stepDistX),
    .i_stepDistY  (stepDistY),
    .i_rayDirX    (rayDirX),
    .i_rayDirY    (rayDirY),
    .i_mapVal     (i_mapVal),
    .o_mapCol     (o_mapCol),
    .o_mapRow     (o_mapRow),
    .o_hit        (hit),
    .o_wall       (wall),
    .o_side       (side),
    .o_visualDist (visualDist)
  );

  rowResult u_rowResult (
    .clk         (clk),
    .do_reset    (do_reset),
    .i_vsync     (i_vsync),
    .i_load      (load),
    .i_wall      (wall),
    .i_side      (side),
    .i_size      (size),
    .i_texU      (texU),
    .o_rowStrobe (o_rowStrobe),
    .o_wall      (o_wall),
    .o_side      (o_side),
    .o_size      (o_size),
    .o_texU      (o_texU)
  );

endmodule

// ==== sim/wallTracer_assert.sv ====
`timescale 1ns/10ps

module wallTracerAssert
  import fixedPkg::*;
#(
  parameter int MAP_W_BITS = 4,
  parameter int MAP_H_BITS = 4,
  parameter int MAP_COLS   = 2 ** MAP_W_BITS,
  parameter int MAP_ROWS   = 2 ** MAP_H_BITS
) (
  input logic clk,
  input logic do_reset,
  input logic i_hmax,
  input logic i_rowStrobe,
  input cellT i_cellX,
  input cellT i_cellY
);

  // The row strobe is a single-cycle pulse
  strobeSingle: assert property (@(posedge clk) disable iff (do_reset)
    i_rowStrobe |=> !i_rowStrobe)
    else $error("row strobe held high for two cycles");

  // A row is only presented one cycle after the line end strobe
  strobeAfterHmax: assert property (@(posedge clk) disable iff (do_reset)
    i_rowStrobe |-> $past(i_hmax))
    else $error("row strobe without a preceding hmax");

  // The walker's full cell coordinate must never leave the map
  // A cell past the edge would otherwise alias onto the truncated map address
  mapInside: assert property (@(posedge clk) disable iff (do_reset)
    !$isunknown({i_cellX, i_cellY}) && int'(i_cellX) < MAP_COLS &&
    int'(i_cellY) < MAP_ROWS)
    else $error("map address outside the map");

endmodule

// ==== sim/traceChecker.sv ====
`timescale 1ns/10ps

module traceChecker
  import fixedPkg::*, tracerPkg::*;
#(
  parameter int ROWS = 5
) (
  input  logic            clk,
  input  logic            do_reset,
  input  logic            i_vsync,
  input  logic            i_rowStrobe,
  input  wallT            i_wall,
  input  logic            i_side,
  input  sizeT            i_size,
  input  texUT            i_texU,
  input  logic [8*12-1:0] i_testName,
  input  int              i_rowIdx,
  input  logic            i_expectRow,
  input  wallT            i_expWall,
  input  logic            i_expSide,
  input  sizeT            i_expSize,
  input  texUT            i_expTexU,
  input  logic            i_testDone,
  input  logic            i_report,
  output int              o_errors,
  output int              o_checks
);

  int   errors = 0;
  int   checks = 0;
  int   testErrors = 0;
  int   rowsSeen = 0;
  // Set for one cycle after reset or vsync, when all row outputs must read zero
  logic clearDue = 1'b0;

  assign o_errors = errors;
  assign o_checks = checks;

  // One field of a row result against the table
  task automatic compareField(input string field, input int expected, input int actual);
    checks = checks + 1;
    if (expected !== actual) begin
      errors     = errors + 1;
      testErrors = testErrors + 1;
      $display("error %0s row %0d %0s: expected %0d, actual %0d",
               i_testName, i_rowIdx, field, expected, actual);
    end
  endtask

  always @(posedge clk) begin
    if (clearDue && {i_rowStrobe, i_wall, i_side, i_size, i_texU} !== '0) begin
      errors     = errors + 1;
      testErrors = testErrors + 1;
      $display("row outputs were not cleared by reset or vsync in test %0s", i_testName);
    end
    clearDue <= do_reset || i_vsync;
    if (!do_reset && i_rowStrobe === 1'b1) begin
      if (!i_expectRow) begin
        errors     = errors + 1;
        testErrors = testErrors + 1;
        $display("row strobe arrived with no row due in test %0s", i_testName);
      end else begin
        rowsSeen = rowsSeen + 1;
        compareField("wall", int'(i_expWall), int'(i_wall));
        compareField("side", int'(i_expSide), int'(i_side));
        compareField("size", int'(i_expSize), int'(i_size));
        compareField("texU", int'(i_expTexU), int'(i_texU));
      end
    end
    // Per-test summary, including rows that never showed up
    if (i_testDone) begin
      if (rowsSeen != ROWS) begin
        errors     = errors + 1;
        testErrors = testErrors + 1;
        $display("test %0s produced %0d row results instead of %0d",
                 i_testName, rowsSeen, ROWS);
      end
      if (testErrors == 0) $display("test %0s: ok", i_testName);
      else $display("test %0s: %0d errors", i_testName, testErrors);
      testErrors = 0;
      rowsSeen   = 0;
    end
    if (i_report) begin
      $display("checks %0d, errors %0d", checks, errors);
    end
  end

endmodule

// ==== sim/wallTracerTb.sv ====
`timescale 1ns/10ps

module wallTracerTb
  import fixedPkg::*, tracerPkg::*;
();

  localparam int NUM_TESTS   = 4;
  localparam int ROWS        = 5;
  localparam int LINE_CYCLES = 400;
  localparam int CYCLE_LIMIT = NUM_TESTS * (ROWS * LINE_CYCLES + 20) + 500;

  logic clk;
  logic do_reset;
  logic vsync;
  logic hmax;
  fixT  playerX;
  fixT  playerY;
  fixT  facingX;
  fixT  facingY;
  fixT  vplaneX;
  fixT  vplaneY;
  logic [3:0] mapCol;
  logic [3:0] mapRow;
  wallT mapVal;
  wallT wall;
  logic rowStrobe;
  logic side;
  sizeT size;
  texUT texU;

  // Test table with the inputs per test and the hand-worked result of every row
  logic [8*12-1:0] tName [NUM_TESTS];
  fixT  tPlayerX [NUM_TESTS];
  fixT  tPlayerY [NUM_TESTS];
  fixT  tFacingX [NUM_TESTS];
  fixT  tFacingY [NUM_TESTS];
  fixT  tVplaneY [NUM_TESTS];
  int   tMap [NUM_TESTS];
  wallT tWall [NUM_TESTS][ROWS];
  logic tSide [NUM_TESTS][ROWS];
  sizeT tSize [NUM_TESTS][ROWS];
  texUT tTexU [NUM_TESTS][ROWS];

  // Current expectation handed to the checker
  logic [8*12-1:0] curName;
  int   curRow;
  logic expectRow;
  logic testDone;
  logic report;
  wallT expWall;
  logic expSide;
  sizeT expSize;
  texUT expTexU;
  int   errors;
  int   checks;
  int   cycles = 0;

  // Map ROM model that answers in the same cycle as the address
  wallT mapMem [0:15][0:15];
  assign mapVal = mapMem[mapRow][mapCol];

  wallTracer #(.MAP_W_BITS(4), .MAP_H_BITS(4), .START_ROWS(2)) u_dut (
    .clk(clk), .do_reset(do_reset), .i_vsync(vsync), .i_hmax(hmax),
    .i_playerX(playerX), .i_playerY(playerY), .i_facingX(facingX), .i_facingY(facingY),
    .i_vplaneX(vplaneX), .i_vplaneY(vplaneY), .o_mapCol(mapCol), .o_mapRow(mapRow),
    .i_mapVal(mapVal), .o_rowStrobe(rowStrobe), .o_wall(wall), .o_side(side),
    .o_size(size), .o_texU(texU)
  );

  bind wallTracer wallTracerAssert #(
    .MAP_W_BITS (MAP_W_BITS),
    .MAP_H_BITS (MAP_H_BITS)
  ) u_assert (
    .clk         (clk),
    .do_reset    (do_reset),
    .i_hmax      (i_hmax),
    .i_rowStrobe (o_rowStrobe),
    .i_cellX     (u_gridWalker.mapX),
    .i_cellY     (u_gridWalker.mapY)
  );

  traceChecker #(.ROWS(ROWS)) u_checker (
    .clk(clk), .do_reset(do_reset), .i_vsync(vsync), .i_rowStrobe(rowStrobe),
    .i_wall(wall), .i_side(side), .i_size(size), .i_texU(texU),
    .i_testName(curName), .i_rowIdx(curRow), .i_expectRow(expectRow),
    .i_expWall(expWall), .i_expSide(expSide), .i_expSize(expSize), .i_expTexU(expTexU),
    .i_testDone(testDone), .i_report(report), .o_errors(errors), .o_checks(checks)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Cycle limit derived from the total length of the stimulus
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timed out waiting for row result");
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // Advance to 2 ns after the next rising edge, where inputs change
  task automatic nextCycles(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic setRow(input int t, input int r, input wallT w, input logic s,
                        input sizeT sz, input texUT u);
    tWall[t][r] = w;
    tSide[t][r] = s;
    tSize[t][r] = sz;
    tTexU[t][r] = u;
  endtask

  task automatic setTest(input int t, input logic [8*12-1:0] name, input fixT px,
                         input fixT py, input fixT fx, input fixT fy, input fixT vy,
                         input int mapSel);
    tName[t]    = name;
    tPlayerX[t] = px;
    tPlayerY[t] = py;
    tFacingX[t] = fx;
    tFacingY[t] = fy;
    tVplaneY[t] = vy;
    tMap[t]     = mapSel;
  endtask

  // Every variant has a border of ID 1
  // Variant 1 adds a wall of ID 2 at column 5 and variant 2 also puts ID 3 at (4,7)
  task automatic buildMap(input int variant);
    for (int r = 0; r < 16; r++) begin
      for (int c = 0; c < 16; c++) begin
        mapMem[r][c] = (r == 0 || r == 15 || c == 0 || c == 15) ? 2'd1 : 2'd0;
        if (variant >= 1 && c == 5 && r > 0 && r < 15) mapMem[r][c] = 2'd2;
      end
    end
    if (variant == 2) mapMem[7][4] = 2'd3;
  endtask

  // Table values are raw Q10.10 with 1024 standing for 1.0
  task automatic loadTable();
    // Distance 2.5 gives size 409 >> 2, hit at y 7.5 gives texU 32
    setTest(0, "axisX", 2560, 7680, 1024, 0, 0, 1);
    // Distance 6.5 to the top border row, hit at x 2.25 gives texU 16
    setTest(1, "axisY", 2304, 7680, 0, -1024, 0, 0);
    // Ray Y raw is -2,-1,0,1,2 over the rows, so the hit fraction crosses 0.5
    setTest(2, "deflect", 2560, 7680, 1024, 0, 256, 1);
    // Track X 683 then tie at 2048 steps Y past the ID 3 cell, hit at 3413
    setTest(3, "diagonal", 2559, 7168, 768, 512, 0, 2);
    for (int r = 0; r < ROWS; r++) begin
      setRow(0, r, 2'd2, 1'b0, 11'd102, 6'd32);
      setRow(1, r, 2'd1, 1'b1, 11'd39, 6'd16);
      setRow(2, r, 2'd2, 1'b0, 11'd102, (r < 2) ? 6'd31 : 6'd32);
      setRow(3, r, 2'd2, 1'b0, 11'd76, 6'd42);
    end
  endtask

  initial begin
    do_reset  = 1'b1;
    vsync     = 1'b0;
    hmax      = 1'b0;
    playerX   = '0;
    playerY   = '0;
    facingX   = '0;
    facingY   = '0;
    vplaneX   = '0;
    vplaneY   = '0;
    curName   = "reset";
    curRow    = 0;
    expectRow = 1'b0;
    testDone  = 1'b0;
    report    = 1'b0;
    expWall   = '0;
    expSide   = 1'b0;
    expSize   = '0;
    expTexU   = '0;
    buildMap(0);
    loadTable();
    nextCycles(5);
    do_reset = 1'b0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      // Inputs change only while vsync holds the frame at its start
      vsync   = 1'b1;
      curName = tName[t];
      playerX = tPlayerX[t];
      playerY = tPlayerY[t];
      facingX = tFacingX[t];
      facingY = tFacingY[t];
      vplaneY = tVplaneY[t];
      buildMap(tMap[t]);
      nextCycles(3);
      vsync = 1'b0;
      // This hmax comes while the first trace is still running and must be ignored
      nextCycles(5);
      hmax = 1'b1;
      nextCycles(1);
      hmax = 1'b0;
      for (int r = 0; r < ROWS; r++) begin
        nextCycles(LINE_CYCLES - 2);
        curRow    = r;
        expWall   = tWall[t][r];
        expSide   = tSide[t][r];
        expSize   = tSize[t][r];
        expTexU   = tTexU[t][r];
        expectRow = 1'b1;
        hmax      = 1'b1;
        nextCycles(1);
        hmax = 1'b0;
        nextCycles(1);
        expectRow = 1'b0;
      end
      testDone = 1'b1;
      nextCycles(1);
      testDone = 1'b0;
    end
    report = 1'b1;
    nextCycles(1);
    report = 1'b0;
    if (errors == 0 && checks == NUM_TESTS * ROWS * 4) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
verilog/fixedPkg.sv
verilog/tracerPkg.sv
verilog/rayStepper.sv
verilog/reciprocalUnit.sv
verilog/gridWalker.sv
verilog/traceControl.sv
verilog/rowResult.sv
verilog/wallTracer.sv
sim/wallTracer_assert.sv
sim/traceChecker.sv
sim/wallTracerTb.sv
